/* buffer_arbiter/buffer_arbiter.sv */
module buffer_arbiter #(
    parameter int BUFFER_NUM = 3,
    parameter int READER_NUM = 1
) (
    input  logic                                        s_wb_clk_i,
    input  logic                                        s_wb_rst_i,
    input  buffer_cfg_pkg::buf_addr_t [BUFFER_NUM-1:0]  buf_addr_i,
    input  logic                                        writer_request_i,
    input  logic                                        writer_release_i,
    input  logic [READER_NUM-1:0]                       reader_request_i,
    input  logic [READER_NUM-1:0]                       reader_release_i,
    output buffer_cfg_pkg::buf_port_t                   writer_o,
    output buffer_cfg_pkg::buf_port_t [READER_NUM-1:0]  reader_o,
    output buffer_cfg_pkg::buf_port_t                   newest_o,
    output buffer_cfg_pkg::refcnt_t [BUFFER_NUM-1:0]    refcnt_o
);
    import buffer_cfg_pkg::*;

    // ownership state
    logic                          writer_valid_q;
    buf_index_t                    writer_index_q;
    logic                          newest_valid_q;
    buf_index_t                    newest_index_q;
    logic [READER_NUM-1:0]         reader_valid_q;
    buf_index_t [READER_NUM-1:0]   reader_index_q;
    refcnt_t [BUFFER_NUM-1:0]      refcnt_q;

    // accepted events for this cycle
    logic                          writer_commit;
    logic                          writer_acquire;
    logic [READER_NUM-1:0]         reader_acquire;
    logic [READER_NUM-1:0]         reader_drop;

    logic [BUFFER_NUM-1:0]         buf_free;
    logic                          free_found;
    buf_index_t                    free_index;
    refcnt_t [BUFFER_NUM-1:0]      refcnt_next;

    // ----------------------------------------------------------------------
    // free buffer search
    // ----------------------------------------------------------------------

    always_comb begin
        for (int b = 0; b < BUFFER_NUM; b++) begin
            buf_free[b] = (refcnt_q[b] == '0)
                && !(newest_valid_q && newest_index_q == buf_index_t'(b))
                && !(writer_valid_q && writer_index_q == buf_index_t'(b));
        end
        free_found = |buf_free;
        // walk down so the lowest free index wins
        free_index = '0;
        for (int b = BUFFER_NUM - 1; b >= 0; b--) begin
            if (buf_free[b]) begin
                free_index = buf_index_t'(b);
            end
        end
    end

    // ----------------------------------------------------------------------
    // event qualification
    // ----------------------------------------------------------------------

    // release beats a request arriving in the same cycle
    assign writer_commit  = writer_release_i && writer_valid_q;
    assign writer_acquire = writer_request_i && !writer_release_i
                            && !writer_valid_q && free_found;

    always_comb begin
        for (int r = 0; r < READER_NUM; r++) begin
            reader_drop[r]    = reader_release_i[r] && reader_valid_q[r];
            reader_acquire[r] = reader_request_i[r] && !reader_release_i[r]
                                && !reader_valid_q[r] && newest_valid_q;
        end
    end

    // net change per buffer over all readers
    always_comb begin
        refcnt_next = refcnt_q;
        for (int b = 0; b < BUFFER_NUM; b++) begin
            for (int r = 0; r < READER_NUM; r++) begin
                if (reader_acquire[r] && newest_index_q == buf_index_t'(b)) begin
                    refcnt_next[b] = refcnt_next[b] + 1'b1;
                end
                if (reader_drop[r] && reader_index_q[r] == buf_index_t'(b)) begin
                    refcnt_next[b] = refcnt_next[b] - 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // state update
    // ----------------------------------------------------------------------

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            writer_valid_q <= 1'b0;
            writer_index_q <= '0;
            newest_valid_q <= 1'b0;
            newest_index_q <= '0;
            reader_valid_q <= '0;
            reader_index_q <= '0;
            refcnt_q       <= '0;
        end else begin
            refcnt_q <= refcnt_next;
            if (writer_commit) begin
                writer_valid_q <= 1'b0;
                newest_valid_q <= 1'b1;
                newest_index_q <= writer_index_q;
            end else if (writer_acquire) begin
                writer_valid_q <= 1'b1;
                writer_index_q <= free_index;
            end
            for (int r = 0; r < READER_NUM; r++) begin
                if (reader_drop[r]) begin
                    reader_valid_q[r] <= 1'b0;
                end else if (reader_acquire[r]) begin
                    reader_valid_q[r] <= 1'b1;
                    reader_index_q[r] <= newest_index_q;
                end
            end
        end
    end

    // addresses follow the register file combinationally
    always_comb begin
        writer_o = '{valid: writer_valid_q, index: writer_index_q,
                     addr: buf_addr_i[writer_index_q]};
        newest_o = '{valid: newest_valid_q, index: newest_index_q,
                     addr: buf_addr_i[newest_index_q]};
        for (int r = 0; r < READER_NUM; r++) begin
            reader_o[r] = '{valid: reader_valid_q[r], index: reader_index_q[r],
                            addr: buf_addr_i[reader_index_q[r]]};
        end
    end

    assign refcnt_o = refcnt_q;

endmodule

/* common/buffer_cfg_pkg.sv */
package buffer_cfg_pkg;

    // ----------------------------------------------------------------------
    // buffer side widths
    // ----------------------------------------------------------------------

    localparam int ADDR_WIDTH   = 32;

    // up to 16 buffers
    localparam int INDEX_WIDTH  = 4;

    localparam int REFCNT_WIDTH = 4;

    typedef logic [ADDR_WIDTH-1:0]   buf_addr_t;
    typedef logic [INDEX_WIDTH-1:0]  buf_index_t;
    typedef logic [REFCNT_WIDTH-1:0] refcnt_t;

    // ----------------------------------------------------------------------
    // port status
    // ----------------------------------------------------------------------

    // buffer held by the writer, by a reader, or the newest one
    typedef struct packed {
        logic       valid;
        buf_index_t index;
        buf_addr_t  addr;
    } buf_port_t;

endpackage

/* common/wb_regs_pkg.sv */
package wb_regs_pkg;

    // ----------------------------------------------------------------------
    // bus widths
    // ----------------------------------------------------------------------

    localparam int WB_ADR_WIDTH = 8;
    localparam int WB_DAT_WIDTH = 32;
    localparam int WB_SEL_WIDTH = 4;

    typedef struct packed {
        logic [WB_ADR_WIDTH-1:0] adr;
        logic [WB_DAT_WIDTH-1:0] dat;
        logic [WB_SEL_WIDTH-1:0] sel;
        logic                    we;
        logic                    stb;
    } wb_req_t;

    // ----------------------------------------------------------------------
    // register map
    // ----------------------------------------------------------------------

    localparam logic [WB_ADR_WIDTH-1:0] ADR_CORE_ID        = 8'h00;
    localparam logic [WB_ADR_WIDTH-1:0] ADR_CORE_VERSION   = 8'h01;
    localparam logic [WB_ADR_WIDTH-1:0] ADR_CORE_CONFIG    = 8'h03;
    localparam logic [WB_ADR_WIDTH-1:0] ADR_NEWEST_INDEX   = 8'h20;
    localparam logic [WB_ADR_WIDTH-1:0] ADR_WRITER_INDEX   = 8'h21;

    // buffer i lives at base plus i
    localparam logic [WB_ADR_WIDTH-1:0] ADR_BUFFER0_ADDR   = 8'h40;
    localparam logic [WB_ADR_WIDTH-1:0] ADR_BUFFER0_REFCNT = 8'h80;

    // core identity
    localparam logic [WB_DAT_WIDTH-1:0] CORE_ID      = 32'h527a_0004;
    localparam logic [WB_DAT_WIDTH-1:0] CORE_VERSION = 32'h0000_0001;

endpackage

/* compile.f */
common/buffer_cfg_pkg.sv
common/wb_regs_pkg.sv
wb_regs/buffer_reg_decode.sv
wb_regs/buffer_reg_readback.sv
buffer_arbiter/buffer_arbiter.sv
source/buffer_manager_top.sv
tb/buffer_arbiter_checker.sv
tb/buffer_manager_tb.sv

/* source/buffer_manager_top.sv */
module buffer_manager_top #(
    parameter int BUFFER_NUM = 3,
    parameter int READER_NUM = 1
) (
    input  logic                                        s_wb_clk_i,
    input  logic                                        s_wb_rst_i,
    input  logic [wb_regs_pkg::WB_ADR_WIDTH-1:0]        s_wb_adr_i,
    input  logic [wb_regs_pkg::WB_DAT_WIDTH-1:0]        s_wb_dat_i,
    input  logic                                        s_wb_we_i,
    input  logic [wb_regs_pkg::WB_SEL_WIDTH-1:0]        s_wb_sel_i,
    input  logic                                        s_wb_stb_i,
    output logic [wb_regs_pkg::WB_DAT_WIDTH-1:0]        s_wb_dat_o,
    output logic                                        s_wb_ack_o,
    input  logic                                        writer_request_i,
    input  logic                                        writer_release_i,
    input  logic [READER_NUM-1:0]                       reader_request_i,
    input  logic [READER_NUM-1:0]                       reader_release_i,
    output buffer_cfg_pkg::buf_port_t                   writer_o,
    output buffer_cfg_pkg::buf_port_t [READER_NUM-1:0]  reader_o,
    output buffer_cfg_pkg::buf_port_t                   newest_o,
    output buffer_cfg_pkg::refcnt_t [BUFFER_NUM-1:0]    status_refcnt_o
);
    import buffer_cfg_pkg::*;
    import wb_regs_pkg::*;

    wb_req_t                   bus_req;
    buf_addr_t [BUFFER_NUM-1:0] buf_addr;

    assign bus_req = '{adr: s_wb_adr_i, dat: s_wb_dat_i, sel: s_wb_sel_i,
                       we: s_wb_we_i, stb: s_wb_stb_i};

    // single cycle bus, no wait states
    assign s_wb_ack_o = s_wb_stb_i;

    buffer_reg_decode #(
        .BUFFER_NUM (BUFFER_NUM)
    ) i_reg_decode (
        .s_wb_clk_i (s_wb_clk_i),
        .s_wb_rst_i (s_wb_rst_i),
        .bus_req_i  (bus_req),
        .buf_addr_o (buf_addr)
    );

    buffer_arbiter #(
        .BUFFER_NUM (BUFFER_NUM),
        .READER_NUM (READER_NUM)
    ) i_buffer_arbiter (
        .s_wb_clk_i       (s_wb_clk_i),
        .s_wb_rst_i       (s_wb_rst_i),
        .buf_addr_i       (buf_addr),
        .writer_request_i (writer_request_i),
        .writer_release_i (writer_release_i),
        .reader_request_i (reader_request_i),
        .reader_release_i (reader_release_i),
        .writer_o         (writer_o),
        .reader_o         (reader_o),
        .newest_o         (newest_o),
        .refcnt_o         (status_refcnt_o)
    );

    buffer_reg_readback #(
        .BUFFER_NUM (BUFFER_NUM)
    ) i_reg_readback (
        .bus_req_i  (bus_req),
        .buf_addr_i (buf_addr),
        .newest_i   (newest_o),
        .writer_i   (writer_o),
        .refcnt_i   (status_refcnt_o),
        .s_wb_dat_o (s_wb_dat_o)
    );

endmodule

/* tb/buffer_arbiter_checker.sv */
module buffer_arbiter_checker #(
    parameter int BUFFER_NUM = 3
) (
    input  logic                                        s_wb_clk_i,
    input  logic                                        s_wb_rst_i,
    input  logic                                        writer_valid_i,
    input  buffer_cfg_pkg::buf_index_t                  writer_index_i,
    input  buffer_cfg_pkg::refcnt_t [BUFFER_NUM-1:0]    refcnt_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import buffer_cfg_pkg::*;

    int unsigned fail_count = 0;

    writer_idle_after_reset: assert property (
        @(posedge s_wb_clk_i) s_wb_rst_i |=> !writer_valid_i
    ) else begin
        fail_count++;
        $error("writer valid high in the cycle after reset");
    end

    // a buffer owned by the writer is never shared with readers
    writer_buffer_unshared: assert property (
        @(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        writer_valid_i |-> refcnt_i[writer_index_i] == refcnt_t'(0)
    ) else begin
        fail_count++;
        $error("writer holds buffer %0d with nonzero count", writer_index_i);
    end

    for (genvar b = 0; b < BUFFER_NUM; b++) begin : g_no_wrap
        refcnt_no_underflow: assert property (
            @(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
            refcnt_i[b] == refcnt_t'(0) |=> refcnt_i[b] != '1
        ) else begin
            fail_count++;
            $error("count of buffer %0d wrapped below zero", b);
        end
    end

endmodule

/* tb/buffer_manager_tb.sv */
module buffer_manager_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import buffer_cfg_pkg::*;
    import wb_regs_pkg::*;

    localparam int BUFFER_NUM     = 3;
    localparam int READER_NUM     = 2;
    localparam int TIMEOUT_CYCLES = 3000;

    // one bit per port pulse
    localparam logic [5:0] EV_WREQ  = 6'b000001;
    localparam logic [5:0] EV_WREL  = 6'b000010;
    localparam logic [5:0] EV_RREQ0 = 6'b000100;
    localparam logic [5:0] EV_RREQ1 = 6'b001000;
    localparam logic [5:0] EV_RREL0 = 6'b010000;
    localparam logic [5:0] EV_RREL1 = 6'b100000;

    logic                           clk;
    logic                           rst;
    logic [WB_ADR_WIDTH-1:0]        wb_adr;
    logic [WB_DAT_WIDTH-1:0]        wb_dat_w;
    logic [WB_DAT_WIDTH-1:0]        wb_dat_r;
    logic                           wb_we;
    logic [WB_SEL_WIDTH-1:0]        wb_sel;
    logic                           wb_stb;
    logic                           wb_ack;
    logic                           writer_request;
    logic                           writer_release;
    logic [READER_NUM-1:0]          reader_request;
    logic [READER_NUM-1:0]          reader_release;
    buf_port_t                      writer_port;
    buf_port_t [READER_NUM-1:0]     reader_port;
    buf_port_t                      newest_port;
    refcnt_t [BUFFER_NUM-1:0]       refcnt;

    // reference model state
    logic                           m_wv;
    buf_index_t                     m_wi;
    logic                           m_nv;
    buf_index_t                     m_ni;
    logic [READER_NUM-1:0]          m_rv;
    buf_index_t                     m_ri [READER_NUM];
    refcnt_t                        m_cnt [BUFFER_NUM];
    buf_addr_t                      m_addr [BUFFER_NUM];

    logic [5:0]                     driven_ev;
    int unsigned                    cycle_count = 0;
    integer                         seed = 32'h200c_a301;

    buffer_manager_top #(
        .BUFFER_NUM (BUFFER_NUM),
        .READER_NUM (READER_NUM)
    ) i_dut (
        .s_wb_clk_i       (clk),
        .s_wb_rst_i       (rst),
        .s_wb_adr_i       (wb_adr),
        .s_wb_dat_i       (wb_dat_w),
        .s_wb_we_i        (wb_we),
        .s_wb_sel_i       (wb_sel),
        .s_wb_stb_i       (wb_stb),
        .s_wb_dat_o       (wb_dat_r),
        .s_wb_ack_o       (wb_ack),
        .writer_request_i (writer_request),
        .writer_release_i (writer_release),
        .reader_request_i (reader_request),
        .reader_release_i (reader_release),
        .writer_o         (writer_port),
        .reader_o         (reader_port),
        .newest_o         (newest_port),
        .status_refcnt_o  (refcnt)
    );

    bind buffer_arbiter buffer_arbiter_checker #(
        .BUFFER_NUM (BUFFER_NUM)
    ) i_checker (
        .s_wb_clk_i     (s_wb_clk_i),
        .s_wb_rst_i     (s_wb_rst_i),
        .writer_valid_i (writer_valid_q),
        .writer_index_i (writer_index_q),
        .refcnt_i       (refcnt_q)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (i_dut.i_buffer_arbiter.i_checker.fail_count != 0) begin
            $display("arbiter assertion failed before cycle %0d", cycle_count);
            $display("sim failed");
            $fatal(1, "assertion failure");
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic buf_addr_t address_for(input int idx);
        return 32'h1000_0a50 + buf_addr_t'(idx) * 32'h0011_0000;
    endfunction

    task automatic reset_model();
        m_wv = 1'b0;
        m_wi = '0;
        m_nv = 1'b0;
        m_ni = '0;
        m_rv = '0;
        for (int r = 0; r < READER_NUM; r++) begin
            m_ri[r] = '0;
        end
        for (int b = 0; b < BUFFER_NUM; b++) begin
            m_cnt[b]  = '0;
            m_addr[b] = '0;
        end
    endtask

    // one clock edge of the allocation rules
    task automatic model_step(input logic [5:0] ev);
        logic       old_nv;
        buf_index_t old_ni;
        logic       found;
        buf_index_t pick;

        old_nv = m_nv;
        old_ni = m_ni;
        found  = 1'b0;
        pick   = '0;
        for (int b = 0; b < BUFFER_NUM; b++) begin
            if (!found && m_cnt[b] == 0 && !(m_nv && m_ni == b) && !(m_wv && m_wi == b)) begin
                found = 1'b1;
                pick  = buf_index_t'(b);
            end
        end
        if (ev[1] && m_wv) begin
            m_wv = 1'b0;
            m_nv = 1'b1;
            m_ni = m_wi;
        end else if (ev[0] && !ev[1] && !m_wv && found) begin
            m_wv = 1'b1;
            m_wi = pick;
        end
        for (int r = 0; r < READER_NUM; r++) begin
            if (ev[4+r] && m_rv[r]) begin
                m_rv[r] = 1'b0;
                m_cnt[m_ri[r]] = m_cnt[m_ri[r]] - 1;
            end else if (ev[2+r] && !ev[4+r] && !m_rv[r] && old_nv) begin
                m_rv[r] = 1'b1;
                m_ri[r] = old_ni;
                m_cnt[old_ni] = m_cnt[old_ni] + 1;
            end
        end
    endtask

    task automatic check_state();
        buf_port_t exp;

        exp = '{valid: m_wv, index: m_wi, addr: m_addr[m_wi]};
        check_value("writer_o", 64'(writer_port), 64'(exp));
        exp = '{valid: m_nv, index: m_ni, addr: m_addr[m_ni]};
        check_value("newest_o", 64'(newest_port), 64'(exp));
        for (int r = 0; r < READER_NUM; r++) begin
            exp = '{valid: m_rv[r], index: m_ri[r], addr: m_addr[m_ri[r]]};
            check_value($sformatf("reader_o[%0d]", r), 64'(reader_port[r]), 64'(exp));
        end
        for (int b = 0; b < BUFFER_NUM; b++) begin
            check_value($sformatf("refcnt[%0d]", b), 64'(refcnt[b]), 64'(m_cnt[b]));
        end
    endtask

    // drive new events; the edge here applies the previous ones
    task automatic cycle(input logic [5:0] ev);
        logic [5:0] applied;

        @(posedge clk);
        applied = driven_ev;
        writer_request <= ev[0];
        writer_release <= ev[1];
        reader_request <= ev[3:2];
        reader_release <= ev[5:4];
        driven_ev = ev;
        @(negedge clk);
        model_step(applied);
        check_state();
    endtask

    task automatic pulse(input logic [5:0] ev);
        cycle(ev);
        cycle('0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        writer_request <= 1'b0;
        writer_release <= 1'b0;
        reader_request <= '0;
        reader_release <= '0;
        driven_ev = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        reset_model();
    endtask

    task automatic write_address(input int idx, input buf_addr_t dat,
                                 input logic [WB_SEL_WIDTH-1:0] sel);
        @(posedge clk);
        wb_adr   <= ADR_BUFFER0_ADDR + WB_ADR_WIDTH'(idx);
        wb_dat_w <= dat;
        wb_sel   <= sel;
        wb_we    <= 1'b1;
        wb_stb   <= 1'b1;
        @(negedge clk);
        check_value("write ack", wb_ack, 1'b1);
        @(posedge clk);
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        for (int lane = 0; lane < WB_SEL_WIDTH; lane++) begin
            if (sel[lane]) begin
                m_addr[idx][8*lane +: 8] = dat[8*lane +: 8];
            end
        end
    endtask

    task automatic read_reg(input logic [WB_ADR_WIDTH-1:0] adr,
                            input logic [WB_DAT_WIDTH-1:0] exp, input string what);
        @(posedge clk);
        wb_adr <= adr;
        wb_we  <= 1'b0;
        wb_stb <= 1'b1;
        @(negedge clk);
        check_value("read ack", wb_ack, 1'b1);
        check_value(what, wb_dat_r, exp);
        @(posedge clk);
        wb_stb <= 1'b0;
    endtask

    task automatic program_addresses();
        for (int b = 0; b < BUFFER_NUM; b++) begin
            write_address(b, address_for(b), 4'b1111);
        end
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------

    task automatic test_registers();
        read_reg(ADR_CORE_ID, 32'h527a_0004, "core id");
        read_reg(ADR_CORE_VERSION, 32'h0000_0001, "core version");
        read_reg(ADR_CORE_CONFIG, 32'd3, "core config");
        program_addresses();
        // only byte lane 1 may change
        write_address(1, 32'hdead_beef, 4'b0010);
        read_reg(ADR_BUFFER0_ADDR + WB_ADR_WIDTH'(1), 32'h1011_be50, "masked buffer address");
        for (int b = 0; b < BUFFER_NUM; b++) begin
            read_reg(ADR_BUFFER0_ADDR + WB_ADR_WIDTH'(b), m_addr[b], "buffer address");
        end
    endtask

    task automatic test_writer_cycle();
        pulse(EV_WREQ);
        check_value("writer valid", writer_port.valid, 1'b1);
        check_value("writer index", writer_port.index, 0);
        check_value("writer addr", writer_port.addr, address_for(0));
        pulse(EV_WREL);
        check_value("newest index", newest_port.index, 0);
        read_reg(ADR_NEWEST_INDEX, 32'd0, "newest index register");
        check_value("writer valid after release", writer_port.valid, 1'b0);
    endtask

    task automatic test_reader_acquire();
        pulse(EV_RREQ0 | EV_RREQ1);
        check_value("reader 0 index", reader_port[0].index, 0);
        check_value("reader 1 index", reader_port[1].index, 0);
        read_reg(ADR_BUFFER0_REFCNT, 32'd2, "buffer 0 count");
        pulse(EV_WREQ);
        check_value("writer avoids shared buffer", writer_port.index, 1);
        read_reg(ADR_WRITER_INDEX, 32'd1, "writer index register");
    endtask

    task automatic test_release_and_ignored();
        pulse(EV_RREL0);
        read_reg(ADR_BUFFER0_REFCNT, 32'd1, "count after first release");
        pulse(EV_RREL1);
        read_reg(ADR_BUFFER0_REFCNT, 32'd0, "count after second release");
        pulse(EV_RREL0);
        check_value("count after repeated release", refcnt[0], 0);
        // fill every buffer so the writer finds none free
        pulse(EV_RREQ0);
        pulse(EV_WREL);
        pulse(EV_RREQ1);
        pulse(EV_WREQ);
        check_value("writer takes last free buffer", writer_port.index, 2);
        pulse(EV_WREL);
        pulse(EV_WREQ);
        check_value("writer request with none free", writer_port.valid, 1'b0);
        read_reg(ADR_NEWEST_INDEX, 32'd2, "newest index register after refill");
        apply_reset();
        pulse(EV_RREQ0);
        check_value("reader request without newest", reader_port[0].valid, 1'b0);
        check_value("count without newest", refcnt[0], 0);
    endtask

    task automatic test_random();
        logic [5:0] ev;

        program_addresses();
        for (int i = 0; i < 400; i++) begin
            ev = 6'($random(seed));
            cycle(ev);
        end
        cycle('0);
    endtask

    initial begin
        rst            = 1'b1;
        wb_adr         = '0;
        wb_dat_w       = '0;
        wb_we          = 1'b0;
        wb_sel         = '0;
        wb_stb         = 1'b0;
        writer_request = 1'b0;
        writer_release = 1'b0;
        reader_request = '0;
        reader_release = '0;
        driven_ev      = '0;
        reset_model();
        apply_reset();
        test_registers();
        test_writer_cycle();
        test_reader_acquire();
        test_release_and_ignored();
        test_random();
        if (i_dut.i_buffer_arbiter.i_checker.fail_count != 0) begin
            $display("arbiter assertions failed %0d times",
                     i_dut.i_buffer_arbiter.i_checker.fail_count);
            $display("sim failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

/* wb_regs/buffer_reg_decode.sv */
module buffer_reg_decode #(
    parameter int BUFFER_NUM = 3
) (
    input  logic                                        s_wb_clk_i,
    input  logic                                        s_wb_rst_i,
    input  wb_regs_pkg::wb_req_t                        bus_req_i,
    output buffer_cfg_pkg::buf_addr_t [BUFFER_NUM-1:0]  buf_addr_o
);
    import buffer_cfg_pkg::*;
    import wb_regs_pkg::*;

    logic bus_write;

    // merge new bytes into the old word by lane
    function automatic logic [WB_DAT_WIDTH-1:0] apply_sel(
        input logic [WB_DAT_WIDTH-1:0] old_val,
        input logic [WB_DAT_WIDTH-1:0] new_val,
        input logic [WB_SEL_WIDTH-1:0] sel
    );
        logic [WB_DAT_WIDTH-1:0] merged;

        merged = old_val;
        for (int lane = 0; lane < WB_SEL_WIDTH; lane++) begin
            if (sel[lane]) begin
                merged[8*lane +: 8] = new_val[8*lane +: 8];
            end
        end
        return merged;
    endfunction

    assign bus_write = bus_req_i.stb && bus_req_i.we;

    // ----------------------------------------------------------------------
    // base address registers
    // ----------------------------------------------------------------------

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            buf_addr_o <= '0;
        end else if (bus_write) begin
            for (int i = 0; i < BUFFER_NUM; i++) begin
                if (bus_req_i.adr == ADR_BUFFER0_ADDR + WB_ADR_WIDTH'(i)) begin
                    buf_addr_o[i] <= ADDR_WIDTH'(apply_sel(
                        WB_DAT_WIDTH'(buf_addr_o[i]),
                        bus_req_i.dat,
                        bus_req_i.sel
                    ));
                end
            end
        end
    end

endmodule

/* wb_regs/buffer_reg_readback.sv */
module buffer_reg_readback #(
    parameter int BUFFER_NUM = 3
) (
    input  wb_regs_pkg::wb_req_t                           bus_req_i,
    input  buffer_cfg_pkg::buf_addr_t [BUFFER_NUM-1:0]     buf_addr_i,
    input  buffer_cfg_pkg::buf_port_t                      newest_i,
    input  buffer_cfg_pkg::buf_port_t                      writer_i,
    input  buffer_cfg_pkg::refcnt_t [BUFFER_NUM-1:0]       refcnt_i,
    output logic [wb_regs_pkg::WB_DAT_WIDTH-1:0]           s_wb_dat_o
);
    import wb_regs_pkg::*;

    logic [WB_DAT_WIDTH-1:0] fixed_data;
    logic [WB_DAT_WIDTH-1:0] table_data;
    logic                    table_hit;

    // ----------------------------------------------------------------------
    // identity and allocation state
    // ----------------------------------------------------------------------

    always_comb begin
        case (bus_req_i.adr)
            ADR_CORE_ID:      fixed_data = CORE_ID;
            ADR_CORE_VERSION: fixed_data = CORE_VERSION;
            ADR_CORE_CONFIG:  fixed_data = WB_DAT_WIDTH'(BUFFER_NUM);
            ADR_NEWEST_INDEX: fixed_data = WB_DAT_WIDTH'(newest_i.index);
            ADR_WRITER_INDEX: fixed_data = WB_DAT_WIDTH'(writer_i.index);
            default:          fixed_data = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // per-buffer address and count windows
    // ----------------------------------------------------------------------

    always_comb begin
        table_data = '0;
        table_hit  = 1'b0;
        for (int i = 0; i < BUFFER_NUM; i++) begin
            if (bus_req_i.adr == ADR_BUFFER0_ADDR + WB_ADR_WIDTH'(i)) begin
                table_data = WB_DAT_WIDTH'(buf_addr_i[i]);
                table_hit  = 1'b1;
            end
            if (bus_req_i.adr == ADR_BUFFER0_REFCNT + WB_ADR_WIDTH'(i)) begin
                table_data = WB_DAT_WIDTH'(refcnt_i[i]);
                table_hit  = 1'b1;
            end
        end
    end

    // unmapped offsets fall through to zero
    assign s_wb_dat_o = table_hit ? table_data : fixed_data;

endmodule
